// File: logic/btb.sv
`timescale 1ns/1ps

module btb import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	// arch state
	input ASID_t arch_asid,

	// read req stage
	input logic read_req_valid,
	input fetch_idx_t read_req_fetch_index,

	// read resp stage
	input PC38_t read_resp_pc38,

	output BTB_info_t [FETCH_LANES-1:0] resp_resp_btb_info_by_lane,
	output logic [FETCH_LANES-1:0] read_resp_hit_by_lane,
	output BTB_way_idx_t [FETCH_LANES-1:0] read_resp_hit_way_by_lane,

	// update
	input logic update_valid,
	input PC38_t update_pc38,
	input BTB_info_t update_btb_info,
	input logic update_hit,
	input BTB_way_idx_t update_hit_way
);

	// array outputs, one cycle after the request
	BTB_tag_t [FETCH_LANES-1:0][BTB_WAYS-1:0] tags_by_lane_way;
	logic [FETCH_LANES-1:0][BTB_WAYS-1:0] valid_by_lane_way;
	BTB_info_t [FETCH_LANES-1:0][BTB_WAYS-1:0] info_by_lane_way;

	BTB_tag_t resp_tag;

	lane_idx_t update_lane;
	fetch_idx_t update_set_index;
	BTB_tag_t update_tag;

	btb_write_t write;

	// ----------------------------------------
	// read side

	// response only needs the tag, set came with the request
	btb_decode resp_decode (
		.pc38(read_resp_pc38),
		.asid(arch_asid),
		.lane(),
		.set_index(),
		.tag(resp_tag)
	);

	btb_array array (
		.CLK(CLK),
		.nRST(nRST),
		.read_valid(read_req_valid),
		.read_index(read_req_fetch_index),
		.write(write),
		.tags_by_lane_way(tags_by_lane_way),
		.valid_by_lane_way(valid_by_lane_way),
		.info_by_lane_way(info_by_lane_way)
	);

	btb_lookup lookup (
		.tags_by_lane_way(tags_by_lane_way),
		.valid_by_lane_way(valid_by_lane_way),
		.info_by_lane_way(info_by_lane_way),
		.tag(resp_tag),
		.hit_by_lane(read_resp_hit_by_lane),
		.hit_way_by_lane(read_resp_hit_way_by_lane),
		.info_by_lane(resp_resp_btb_info_by_lane)
	);

	// ----------------------------------------
	// update side

	btb_decode update_decode (
		.pc38(update_pc38),
		.asid(arch_asid),
		.lane(update_lane),
		.set_index(update_set_index),
		.tag(update_tag)
	);

	btb_update update (
		.CLK(CLK),
		.nRST(nRST),
		.update_valid(update_valid),
		.lane(update_lane),
		.set_index(update_set_index),
		.tag(update_tag),
		.update_btb_info(update_btb_info),
		.update_hit(update_hit),
		.update_hit_way(update_hit_way),
		.write(write)
	);

endmodule

// File: logic/btb_array.sv
`timescale 1ns/1ps

module btb_array import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	// read port
	input logic read_valid,
	input fetch_idx_t read_index,

	// write port
	input btb_write_t write,

	// registered read data, all ways of all lanes
	output BTB_tag_t [FETCH_LANES-1:0][BTB_WAYS-1:0] tags_by_lane_way,
	output logic [FETCH_LANES-1:0][BTB_WAYS-1:0] valid_by_lane_way,
	output BTB_info_t [FETCH_LANES-1:0][BTB_WAYS-1:0] info_by_lane_way
);

	// ----------------------------------------
	// storage

	btb_entry_t entry_mem [FETCH_LANES][BTB_WAYS][BTB_SETS];
	logic [BTB_SETS-1:0] valid_bits [FETCH_LANES][BTB_WAYS];

	// entry memory, no reset
	always_ff @(posedge CLK) begin
		if (write.valid) begin
			entry_mem[write.lane][write.way][write.set_index] <= write.entry;
		end
	end

	// valid bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int l = 0; l < FETCH_LANES; l++) begin
				for (int w = 0; w < BTB_WAYS; w++) begin
					valid_bits[l][w] <= '0;
				end
			end
		end else if (write.valid) begin
			valid_bits[write.lane][write.way][write.set_index] <= 1'b1;
		end
	end

	// ----------------------------------------
	// read registers

	// same-edge write is not forwarded, read sees old contents
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			valid_by_lane_way <= '0;
		end else if (read_valid) begin
			for (int l = 0; l < FETCH_LANES; l++) begin
				for (int w = 0; w < BTB_WAYS; w++) begin
					valid_by_lane_way[l][w] <= valid_bits[l][w][read_index];
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (read_valid) begin
			for (int l = 0; l < FETCH_LANES; l++) begin
				for (int w = 0; w < BTB_WAYS; w++) begin
					tags_by_lane_way[l][w] <= entry_mem[l][w][read_index].tag;
					info_by_lane_way[l][w] <= entry_mem[l][w][read_index].info;
				end
			end
		end
	end

endmodule

// File: logic/btb_decode.sv
`timescale 1ns/1ps

module btb_decode import btb_pkg::*; (
	input PC38_t pc38,
	input ASID_t asid,

	output lane_idx_t lane,
	output fetch_idx_t set_index,
	output BTB_tag_t tag
);

	// address bits above the set index
	logic [UPPER_BITS-1:0] upper;

	// pc layout: upper | set | lane
	assign lane = pc38[LANE_BITS-1:0];
	assign set_index = pc38[LANE_BITS +: SET_BITS];
	assign upper = pc38[PC_BITS-1 -: UPPER_BITS];

	// fold upper address in tag-wide slices, seeded with the asid
	// so the same pc under another asid lands on a different tag
	always_comb begin
		tag = BTB_tag_t'(asid);
		for (int i = 0; i < UPPER_BITS; i++) begin
			tag[i % TAG_BITS] = tag[i % TAG_BITS] ^ upper[i];
		end
	end

endmodule

// File: logic/btb_lookup.sv
`timescale 1ns/1ps

module btb_lookup import btb_pkg::*; (
	input BTB_tag_t [FETCH_LANES-1:0][BTB_WAYS-1:0] tags_by_lane_way,
	input logic [FETCH_LANES-1:0][BTB_WAYS-1:0] valid_by_lane_way,
	input BTB_info_t [FETCH_LANES-1:0][BTB_WAYS-1:0] info_by_lane_way,
	input BTB_tag_t tag,

	output logic [FETCH_LANES-1:0] hit_by_lane,
	output BTB_way_idx_t [FETCH_LANES-1:0] hit_way_by_lane,
	output BTB_info_t [FETCH_LANES-1:0] info_by_lane
);

	// ----------------------------------------
	// tag compare

	logic [FETCH_LANES-1:0][BTB_WAYS-1:0] match_by_lane_way;

	always_comb begin
		for (int l = 0; l < FETCH_LANES; l++) begin
			for (int w = 0; w < BTB_WAYS; w++) begin
				match_by_lane_way[l][w] = valid_by_lane_way[l][w]
					&& (tags_by_lane_way[l][w] == tag);
			end
		end
	end

	// ----------------------------------------
	// way select

	// walk ways high to low so the lowest match is the last one written
	// no match leaves way and info at zero
	always_comb begin
		hit_by_lane = '0;
		hit_way_by_lane = '0;
		info_by_lane = '0;
		for (int l = 0; l < FETCH_LANES; l++) begin
			hit_by_lane[l] = |match_by_lane_way[l];
			for (int w = BTB_WAYS - 1; w >= 0; w--) begin
				if (match_by_lane_way[l][w]) begin
					hit_way_by_lane[l] = BTB_way_idx_t'(w);
					info_by_lane[l] = info_by_lane_way[l][w];
				end
			end
		end
	end

endmodule

// File: logic/btb_pkg.sv
package btb_pkg;

	// ----------------------------------------
	// geometry

	localparam int FETCH_LANES = 4;
	localparam int BTB_WAYS = 2;
	localparam int BTB_SETS = 128;

	// field widths
	localparam int PC_BITS = 38;
	localparam int ASID_BITS = 9;
	localparam int LANE_BITS = $clog2(FETCH_LANES);
	localparam int SET_BITS = $clog2(BTB_SETS);
	localparam int WAY_BITS = $clog2(BTB_WAYS);
	localparam int TAG_BITS = 10;
	localparam int UPPER_BITS = PC_BITS - SET_BITS - LANE_BITS;

	// stored branch info
	localparam int BRANCH_TYPE_BITS = 2;
	localparam int TARGET_LOW_BITS = 12;

	// ----------------------------------------
	// vector types

	typedef logic [ASID_BITS-1:0] ASID_t;
	typedef logic [PC_BITS-1:0] PC38_t;
	typedef logic [SET_BITS-1:0] fetch_idx_t;
	typedef logic [LANE_BITS-1:0] lane_idx_t;
	typedef logic [TAG_BITS-1:0] BTB_tag_t;
	typedef logic [WAY_BITS-1:0] BTB_way_idx_t;

	// ----------------------------------------
	// structs

	typedef struct packed {
		logic [BRANCH_TYPE_BITS-1:0] branch_type;
		logic [TARGET_LOW_BITS-1:0] target_low;
	} BTB_info_t;

	// what one way of one lane holds
	typedef struct packed {
		BTB_tag_t tag;
		BTB_info_t info;
	} btb_entry_t;

	// single write port request into the array
	typedef struct packed {
		logic valid;
		fetch_idx_t set_index;
		lane_idx_t lane;
		BTB_way_idx_t way;
		btb_entry_t entry;
	} btb_write_t;

endpackage

// File: logic/btb_update.sv
`timescale 1ns/1ps

module btb_update import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	input logic update_valid,
	input lane_idx_t lane,
	input fetch_idx_t set_index,
	input BTB_tag_t tag,
	input BTB_info_t update_btb_info,
	input logic update_hit,
	input BTB_way_idx_t update_hit_way,

	output btb_write_t write
);

	// one round-robin pointer per set, per lane
	BTB_way_idx_t rr_way [FETCH_LANES][BTB_SETS];

	BTB_way_idx_t victim_way;

	assign victim_way = rr_way[lane][set_index];

	// hit rewrites in place, miss goes to the victim
	always_comb begin
		write.valid = update_valid;
		write.set_index = set_index;
		write.lane = lane;
		write.way = update_hit ? update_hit_way : victim_way;
		write.entry.tag = tag;
		write.entry.info = update_btb_info;
	end

	// ----------------------------------------
	// replacement state

	// advance only on a miss, wraps at BTB_WAYS
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int l = 0; l < FETCH_LANES; l++) begin
				for (int s = 0; s < BTB_SETS; s++) begin
					rr_way[l][s] <= '0;
				end
			end
		end else if (update_valid && !update_hit) begin
			if (victim_way == BTB_way_idx_t'(BTB_WAYS - 1)) begin
				rr_way[lane][set_index] <= '0;
			end else begin
				rr_way[lane][set_index] <= victim_way + BTB_way_idx_t'(1);
			end
		end
	end

endmodule

// File: logic/btb_wrapper.sv
`timescale 1ns/1ps

module btb_wrapper import btb_pkg::*; (
	input logic CLK,
	input logic nRST,

	// arch state
	input ASID_t next_arch_asid,

	// read req stage
	input logic next_read_req_valid,
	input fetch_idx_t next_read_req_fetch_index,

	// read resp stage
	input PC38_t next_read_resp_pc38,

	output BTB_info_t [FETCH_LANES-1:0] last_resp_resp_btb_info_by_lane,
	output logic [FETCH_LANES-1:0] last_read_resp_hit_by_lane,
	output BTB_way_idx_t [FETCH_LANES-1:0] last_read_resp_hit_way_by_lane,

	// update
	input logic next_update_valid,
	input PC38_t next_update_pc38,
	input BTB_info_t next_update_btb_info,
	input logic next_update_hit,
	input BTB_way_idx_t next_update_hit_way
);

	// ----------------------------------------
	// core side signals

	ASID_t arch_asid;
	logic read_req_valid;
	fetch_idx_t read_req_fetch_index;
	PC38_t read_resp_pc38;

	BTB_info_t [FETCH_LANES-1:0] resp_resp_btb_info_by_lane;
	logic [FETCH_LANES-1:0] read_resp_hit_by_lane;
	BTB_way_idx_t [FETCH_LANES-1:0] read_resp_hit_way_by_lane;

	logic update_valid;
	PC38_t update_pc38;
	BTB_info_t update_btb_info;
	logic update_hit;
	BTB_way_idx_t update_hit_way;

	btb btb_inst (.*);

	// ----------------------------------------
	// boundary registers

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			arch_asid <= '0;
			read_req_valid <= 1'b0;
			read_req_fetch_index <= '0;
			read_resp_pc38 <= '0;

			last_resp_resp_btb_info_by_lane <= '0;
			last_read_resp_hit_by_lane <= '0;
			last_read_resp_hit_way_by_lane <= '0;

			update_valid <= 1'b0;
			update_pc38 <= '0;
			update_btb_info <= '0;
			update_hit <= 1'b0;
			update_hit_way <= '0;
		end else begin
			arch_asid <= next_arch_asid;
			read_req_valid <= next_read_req_valid;
			read_req_fetch_index <= next_read_req_fetch_index;
			read_resp_pc38 <= next_read_resp_pc38;

			last_resp_resp_btb_info_by_lane <= resp_resp_btb_info_by_lane;
			last_read_resp_hit_by_lane <= read_resp_hit_by_lane;
			last_read_resp_hit_way_by_lane <= read_resp_hit_way_by_lane;

			update_valid <= next_update_valid;
			update_pc38 <= next_update_pc38;
			update_btb_info <= next_update_btb_info;
			update_hit <= next_update_hit;
			update_hit_way <= next_update_hit_way;
		end
	end

endmodule

// File: tests/btb_model.svh
`ifndef BTB_MODEL_SVH
`define BTB_MODEL_SVH

// expected per-lane response of one read
typedef struct packed {
	logic [FETCH_LANES-1:0] hit;
	BTB_way_idx_t [FETCH_LANES-1:0] way;
	BTB_info_t [FETCH_LANES-1:0] info;
} lookup_result_t;

// model contents, indexed lane, way, set
bit m_valid [FETCH_LANES][BTB_WAYS][BTB_SETS];
BTB_tag_t m_tag [FETCH_LANES][BTB_WAYS][BTB_SETS];
BTB_info_t m_info [FETCH_LANES][BTB_WAYS][BTB_SETS];
BTB_way_idx_t m_rr [FETCH_LANES][BTB_SETS];

function automatic void model_reset();
	for (int l = 0; l < FETCH_LANES; l++) begin
		for (int s = 0; s < BTB_SETS; s++) begin
			m_rr[l][s] = '0;
			for (int w = 0; w < BTB_WAYS; w++) begin
				m_valid[l][w][s] = 1'b0;
				m_tag[l][w][s] = '0;
				m_info[l][w][s] = '0;
			end
		end
	end
endfunction

// upper address is pc[37:9], xor of its 10-bit slices and the asid
function automatic BTB_tag_t model_tag(input PC38_t pc, input ASID_t asid);
	logic [28:0] upper;
	upper = pc[37:9];
	return BTB_tag_t'(asid) ^ upper[9:0] ^ upper[19:10] ^ BTB_tag_t'(upper[28:20]);
endfunction

// lowest matching valid way wins, zeros on a miss
function automatic lookup_result_t model_lookup(input fetch_idx_t set, input BTB_tag_t tag);
	lookup_result_t r;
	r = '0;
	for (int l = 0; l < FETCH_LANES; l++) begin
		for (int w = 0; w < BTB_WAYS; w++) begin
			if (!r.hit[l] && m_valid[l][w][set] && m_tag[l][w][set] == tag) begin
				r.hit[l] = 1'b1;
				r.way[l] = BTB_way_idx_t'(w);
				r.info[l] = m_info[l][w][set];
			end
		end
	end
	return r;
endfunction

// hit writes the given way, miss takes the round-robin way and flips it
function automatic void model_update(input PC38_t pc, input BTB_tag_t tag,
		input BTB_info_t info, input logic hit, input BTB_way_idx_t hit_way);
	lane_idx_t lane;
	fetch_idx_t set;
	BTB_way_idx_t w;
	lane = pc[1:0];
	set = pc[8:2];
	w = hit ? hit_way : m_rr[lane][set];
	if (!hit) begin
		m_rr[lane][set] = ~m_rr[lane][set];
	end
	m_valid[lane][w][set] = 1'b1;
	m_tag[lane][w][set] = tag;
	m_info[lane][w][set] = info;
endfunction

`endif

// File: tests/btb_tb.sv
`timescale 1ns/1ps

module btb_tb import btb_pkg::*; ();

	// ----------------------------------------
	// run length

	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_CYCLES = 24;
	localparam int RAND_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 4;
	localparam int STIM_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

	// four tags in set 37, lane 2
	localparam PC38_t PC_A = {29'h00ab_cdef, 7'd37, 2'd2};
	localparam PC38_t PC_B = {29'h00ab_c9ef, 7'd37, 2'd2};
	localparam PC38_t PC_C = {29'h0135_79bd, 7'd37, 2'd2};
	localparam PC38_t PC_D = {29'h00f0_f0f0, 7'd37, 2'd2};

	`include "btb_model.svh"

	typedef struct packed {
		logic valid;
		PC38_t pc;
		BTB_info_t info;
		logic hit;
		BTB_way_idx_t way;
	} update_req_t;

	logic CLK;
	logic nRST;
	ASID_t next_arch_asid;
	logic next_read_req_valid;
	fetch_idx_t next_read_req_fetch_index;
	PC38_t next_read_resp_pc38;
	BTB_info_t [FETCH_LANES-1:0] last_resp_resp_btb_info_by_lane;
	logic [FETCH_LANES-1:0] last_read_resp_hit_by_lane;
	BTB_way_idx_t [FETCH_LANES-1:0] last_read_resp_hit_way_by_lane;
	logic next_update_valid;
	PC38_t next_update_pc38;
	BTB_info_t next_update_btb_info;
	logic next_update_hit;
	BTB_way_idx_t next_update_hit_way;

	// stimulus slot for the next cycle
	ASID_t cur_asid;
	logic rd_valid;
	PC38_t rd_pc;
	update_req_t upd;

	// driven last cycle, still in flight
	logic pend_rd;
	PC38_t pend_pc;
	update_req_t pend_upd;
	BTB_tag_t pend_upd_tag;

	lookup_result_t exp_q [$];
	int due_q [$];
	int cyc = 0;

	btb_wrapper btb_wrapper_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ----------------------------------------
	// failure handling and checks

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_hit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_way(input string name, input BTB_way_idx_t got,
			input BTB_way_idx_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_info(input string name, input BTB_info_t got, input BTB_info_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	// cycle count and timeout
	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cyc);
			abort_run();
		end
	end

	// outputs only move on the rising edge
	always @(negedge CLK) begin : compare_results
		lookup_result_t expected;
		if (due_q.size() > 0) begin
			if (due_q[0] < cyc) begin
				$display("expected result due at cycle %0d was never compared", due_q[0]);
				abort_run();
			end else if (due_q[0] == cyc) begin
				expected = exp_q.pop_front();
				void'(due_q.pop_front());
				for (int l = 0; l < FETCH_LANES; l++) begin
					check_hit($sformatf("last_read_resp_hit_by_lane[%0d]", l),
						last_read_resp_hit_by_lane[l], expected.hit[l]);
					check_way($sformatf("last_read_resp_hit_way_by_lane[%0d]", l),
						last_read_resp_hit_way_by_lane[l], expected.way[l]);
					check_info($sformatf("last_resp_resp_btb_info_by_lane[%0d]", l),
						last_resp_resp_btb_info_by_lane[l], expected.info[l]);
				end
			end
		end
	end

	// ----------------------------------------
	// stimulus

	task automatic issue_read(input PC38_t pc);
		rd_valid = 1'b1;
		rd_pc = pc;
	endtask

	task automatic issue_update(input PC38_t pc, input BTB_info_t info, input logic hit,
			input BTB_way_idx_t way);
		upd = '{valid: 1'b1, pc: pc, info: info, hit: hit, way: way};
	endtask

	// one clock of stimulus, the model follows the design's cycle
	task automatic tick();
		@(posedge CLK);
		#1;
		// response half of last cycle's read, tag uses this cycle's asid
		if (pend_rd) begin
			exp_q.push_back(model_lookup(pend_pc[8:2], model_tag(pend_pc, cur_asid)));
			due_q.push_back(cyc + 2);
		end
		next_read_resp_pc38 = pend_pc;
		// last cycle's update lands in the same edge as last cycle's read
		if (pend_upd.valid) begin
			model_update(pend_upd.pc, pend_upd_tag, pend_upd.info, pend_upd.hit, pend_upd.way);
		end
		pend_rd = rd_valid;
		pend_pc = rd_pc;
		pend_upd = upd;
		pend_upd_tag = model_tag(upd.pc, cur_asid);

		next_arch_asid = cur_asid;
		next_read_req_valid = rd_valid;
		next_read_req_fetch_index = rd_pc[8:2];
		next_update_valid = upd.valid;
		next_update_pc38 = upd.pc;
		next_update_btb_info = upd.info;
		next_update_hit = upd.hit;
		next_update_hit_way = upd.way;
		rd_valid = 1'b0;
		upd.valid = 1'b0;
	endtask

	// few sets and tags so entries collide and hit
	function automatic PC38_t rand_pc();
		logic [28:0] upper;
		upper = 29'h00ab_cdef;
		upper[11:10] = 2'($urandom % 3);
		return {upper, fetch_idx_t'(16 + $urandom % 4), lane_idx_t'($urandom)};
	endfunction

	task automatic random_cycle();
		if ($urandom % 4 != 0) begin
			issue_read(rand_pc());
		end
		if ($urandom % 3 == 0) begin
			issue_update(rand_pc(), BTB_info_t'($urandom), ($urandom % 4) == 0,
				BTB_way_idx_t'($urandom));
		end
		if ($urandom % 16 == 0) begin
			cur_asid = cur_asid ^ 9'h1a5;
		end
	endtask

	initial begin
		void'($urandom(32'h289e_a3b5));
		model_reset();
		nRST = 1'b0;
		next_arch_asid = '0;
		next_read_req_valid = 1'b0;
		next_read_req_fetch_index = '0;
		next_read_resp_pc38 = '0;
		next_update_valid = 1'b0;
		next_update_pc38 = '0;
		next_update_btb_info = '0;
		next_update_hit = 1'b0;
		next_update_hit_way = '0;
		cur_asid = '0;
		rd_valid = 1'b0;
		rd_pc = '0;
		upd = '0;
		pend_rd = 1'b0;
		pend_pc = '0;
		pend_upd = '0;
		pend_upd_tag = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nRST = 1'b1;

		// empty after reset
		repeat (8) begin
			issue_read(PC38_t'({$urandom, $urandom}));
			tick();
		end

		// first miss update, a read in the same cycle still misses
		cur_asid = 9'h011;
		issue_update(PC_A, BTB_info_t'{2'd1, 12'h111}, 1'b0, 1'b0);
		issue_read(PC_A);
		tick();
		tick();
		issue_read(PC_A);
		tick();

		// round robin fills way 1, then way 0 again
		issue_update(PC_B, BTB_info_t'{2'd2, 12'h222}, 1'b0, 1'b0);
		tick();
		issue_update(PC_C, BTB_info_t'{2'd3, 12'h333}, 1'b0, 1'b0);
		tick();
		issue_read(PC_A);
		tick();
		issue_read(PC_B);
		tick();
		issue_read(PC_C);
		tick();

		// same pc, other asid
		cur_asid = 9'h0a4;
		issue_read(PC_C);
		tick();
		tick();
		cur_asid = 9'h011;

		// hit rewrite, then a miss goes to the victim
		issue_update(PC_C, BTB_info_t'{2'd0, 12'habc}, 1'b1, 1'b0);
		tick();
		issue_update(PC_D, BTB_info_t'{2'd1, 12'h444}, 1'b0, 1'b0);
		tick();
		issue_read(PC_C);
		tick();
		issue_read(PC_D);
		tick();
		issue_read(PC_B);
		tick();
		tick();

		repeat (RAND_CYCLES) begin
			random_cycle();
			tick();
		end
		repeat (DRAIN_CYCLES) tick();

		if (exp_q.size() != 0) begin
			$display("%0d expected results were left unchecked", exp_q.size());
			abort_run();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: verilog.f
+incdir+tests
logic/btb_pkg.sv
logic/btb_decode.sv
logic/btb_array.sv
logic/btb_lookup.sv
logic/btb_update.sv
logic/btb.sv
logic/btb_wrapper.sv
tests/btb_tb.sv
